// ==== common/mem_pkg.sv ====
// shared op codes, exception codes and CP0 field layout, referenced by package scope
package mem_pkg;

    // general data and address word
    typedef logic [31:0] word_t;

    // stage ops, encoded as the execute-stage decoder emits them
    typedef enum logic [7:0] {
        OP_NONE = 8'b0000_0000,
        OP_LB   = 8'b1110_0000,
        OP_LH   = 8'b1110_0001,
        OP_LW   = 8'b1110_0011,
        OP_LBU  = 8'b1110_0100,
        OP_LHU  = 8'b1110_0101,
        OP_SB   = 8'b1110_1000,
        OP_SH   = 8'b1110_1001,
        OP_SW   = 8'b1110_1011,
        OP_LL   = 8'b1111_0000,
        OP_SC   = 8'b1111_1000
    } aluop_t;

    // one bus word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

    // source of the register writeback data
    typedef enum logic [1:0] {
        WB_EXE     = 2'd0,
        WB_LOAD    = 2'd1,
        WB_SC_OK   = 2'd2,
        WB_SC_FAIL = 2'd3
    } wb_sel_t;

    // bit positions in the incoming excepttype word
    localparam int SYSCALL_IDX     = 8;
    localparam int INSTINVALID_IDX = 9;
    localparam int TRAP_IDX        = 10;
    localparam int OVERFLOW_IDX    = 11;
    localparam int ERET_IDX        = 12;
    localparam int BREAK_IDX       = 13;
    localparam int ADEL_IDX        = 14;
    localparam int ADES_IDX        = 15;

    // final exception codes handed to CP0
    localparam word_t EXC_INT     = 32'h0000_0001;
    localparam word_t EXC_ADEL    = 32'h0000_0004;
    localparam word_t EXC_ADES    = 32'h0000_0005;
    localparam word_t EXC_SYSCALL = 32'h0000_0008;
    localparam word_t EXC_BREAK   = 32'h0000_0009;
    localparam word_t EXC_RI      = 32'h0000_000A;
    localparam word_t EXC_OV      = 32'h0000_000C;
    localparam word_t EXC_TRAP    = 32'h0000_000D;
    localparam word_t EXC_ERET    = 32'h0000_000E;

    // CP0 register numbers
    localparam logic [4:0] CP0_STATUS = 5'd12;
    localparam logic [4:0] CP0_CAUSE  = 5'd13;
    localparam logic [4:0] CP0_EPC    = 5'd14;

    // Status and Cause field positions
    localparam int STATUS_IE  = 0;
    localparam int STATUS_EXL = 1;
    localparam int IP_LO      = 8;
    localparam int IP_HI      = 15;
    localparam int CAUSE_WP   = 22;
    localparam int CAUSE_IV   = 23;

endpackage

// ==== exception/cp0_forward.sv ====
// resolves the newest Status, Cause and EPC by bypassing the writeback-stage CP0 write
`timescale 1ns/1ps

module cp0_forward (
    input  mem_pkg::word_t cp0_status_i,
    input  mem_pkg::word_t cp0_cause_i,
    input  mem_pkg::word_t cp0_epc_i,
    input  logic           wb_cp0_we_i,
    input  logic [4:0]     wb_cp0_addr_i,
    input  mem_pkg::word_t wb_cp0_data_i,
    output mem_pkg::word_t status_o,
    output mem_pkg::word_t cause_o,
    output mem_pkg::word_t epc_o
);

    logic hit_status;
    logic hit_cause;
    logic hit_epc;

    assign hit_status = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::CP0_STATUS);
    assign hit_cause  = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::CP0_CAUSE);
    assign hit_epc    = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::CP0_EPC);

    // Status and EPC are fully writable
    assign status_o = hit_status ? wb_cp0_data_i : cp0_status_i;
    assign epc_o    = hit_epc ? wb_cp0_data_i : cp0_epc_i;

    // only software IP, WP and IV take the new value
    always_comb
    begin
        cause_o = cp0_cause_i;
        if (hit_cause)
        begin
            cause_o[mem_pkg::IP_LO+1:mem_pkg::IP_LO] =
                wb_cp0_data_i[mem_pkg::IP_LO+1:mem_pkg::IP_LO];
            cause_o[mem_pkg::CAUSE_WP] = wb_cp0_data_i[mem_pkg::CAUSE_WP];
            cause_o[mem_pkg::CAUSE_IV] = wb_cp0_data_i[mem_pkg::CAUSE_IV];
        end
    end

endmodule

// ==== exception/except_arbiter.sv ====
// picks the one exception code this instruction reports and the faulting address
`timescale 1ns/1ps

module except_arbiter (
    input  logic           rst_n_i,
    input  mem_pkg::word_t excepttype_i,
    input  mem_pkg::word_t inst_addr_i,
    input  mem_pkg::word_t mem_addr_i,
    input  mem_pkg::word_t status_i,
    input  mem_pkg::word_t cause_i,
    output mem_pkg::word_t excepttype_o,
    output logic           except_o,
    output mem_pkg::word_t badvaddr_o
);

    logic int_taken;

    // pending and unmasked, outside exception level, globally enabled
    assign int_taken = (|(cause_i[mem_pkg::IP_HI:mem_pkg::IP_LO] &
                          status_i[mem_pkg::IP_HI:mem_pkg::IP_LO])) &&
                       !status_i[mem_pkg::STATUS_EXL] &&
                       status_i[mem_pkg::STATUS_IE];

    always_comb
    begin
        excepttype_o = '0;
        // a zero pc marks a bubble
        if (rst_n_i && (inst_addr_i != '0))
        begin
            if (int_taken)
                excepttype_o = mem_pkg::EXC_INT;
            else if (excepttype_i[mem_pkg::SYSCALL_IDX])
                excepttype_o = mem_pkg::EXC_SYSCALL;
            else if (excepttype_i[mem_pkg::BREAK_IDX])
                excepttype_o = mem_pkg::EXC_BREAK;
            else if (excepttype_i[mem_pkg::INSTINVALID_IDX])
                excepttype_o = mem_pkg::EXC_RI;
            else if (excepttype_i[mem_pkg::TRAP_IDX])
                excepttype_o = mem_pkg::EXC_TRAP;
            else if (excepttype_i[mem_pkg::OVERFLOW_IDX])
                excepttype_o = mem_pkg::EXC_OV;
            else if (excepttype_i[mem_pkg::ADEL_IDX])
                excepttype_o = mem_pkg::EXC_ADEL;
            else if (excepttype_i[mem_pkg::ADES_IDX])
                excepttype_o = mem_pkg::EXC_ADES;
            else if (excepttype_i[mem_pkg::ERET_IDX])
                excepttype_o = mem_pkg::EXC_ERET;
        end
    end

    assign except_o = |excepttype_o;

    // misaligned pc means the fetch faulted, otherwise the data address did
    assign badvaddr_o = (inst_addr_i[1:0] != 2'b00) ? inst_addr_i : mem_addr_i;

endmodule

// ==== access/mem_access_ctrl.sv ====
// turns the stage op into data-bus controls, writeback source and load-link update
`timescale 1ns/1ps

module mem_access_ctrl (
    input  mem_pkg::aluop_t  aluop_i,
    input  mem_pkg::word_t   mem_addr_i,
    input  mem_pkg::word_t   reg2_i,
    input  logic             except_i,
    input  logic             llbit_i,
    input  logic             mem_data_valid_i,
    input  logic             mem_write_ready_i,
    output logic             mem_ce_o,
    output logic             mem_we_o,
    output mem_pkg::word_t   mem_addr_o,
    output logic [3:0]       mem_sel_o,
    output mem_pkg::word_t   mem_data_o,
    output mem_pkg::wb_sel_t wb_sel_o,
    output logic             ll_we_o,
    output logic             ll_value_o,
    output logic             stall_o
);

    logic [3:0]         byte_sel;
    logic [3:0]         half_sel;
    mem_pkg::mem_word_u byte_rep;
    mem_pkg::mem_word_u half_rep;

    // lane enables from the low address bits
    assign byte_sel = 4'b0001 << mem_addr_i[1:0];
    assign half_sel = mem_addr_i[1] ? 4'b1100 : 4'b0011;

    // store data copied into every lane, the select picks the right one
    assign byte_rep.bytes  = {4{reg2_i[7:0]}};
    assign half_rep.halves = {2{reg2_i[15:0]}};

    always_comb
    begin
        mem_ce_o   = 1'b0;
        mem_we_o   = 1'b0;
        mem_sel_o  = 4'b0000;
        mem_data_o = '0;
        wb_sel_o   = mem_pkg::WB_EXE;
        ll_we_o    = 1'b0;
        ll_value_o = 1'b0;
        // an excepted instruction never reaches the bus
        if (!except_i)
        begin
            case (aluop_i)
                mem_pkg::OP_LB, mem_pkg::OP_LBU:
                begin
                    mem_ce_o  = 1'b1;
                    mem_sel_o = byte_sel;
                    wb_sel_o  = mem_pkg::WB_LOAD;
                end
                mem_pkg::OP_LH, mem_pkg::OP_LHU:
                begin
                    mem_ce_o  = 1'b1;
                    mem_sel_o = half_sel;
                    wb_sel_o  = mem_pkg::WB_LOAD;
                end
                mem_pkg::OP_LW:
                begin
                    mem_ce_o  = 1'b1;
                    mem_sel_o = 4'b1111;
                    wb_sel_o  = mem_pkg::WB_LOAD;
                end
                mem_pkg::OP_LL:
                begin
                    mem_ce_o   = 1'b1;
                    mem_sel_o  = 4'b1111;
                    wb_sel_o   = mem_pkg::WB_LOAD;
                    ll_we_o    = 1'b1;
                    ll_value_o = 1'b1;
                end
                mem_pkg::OP_SB:
                begin
                    mem_ce_o   = 1'b1;
                    mem_we_o   = 1'b1;
                    mem_sel_o  = byte_sel;
                    mem_data_o = byte_rep;
                end
                mem_pkg::OP_SH:
                begin
                    mem_ce_o   = 1'b1;
                    mem_we_o   = 1'b1;
                    mem_sel_o  = half_sel;
                    mem_data_o = half_rep;
                end
                mem_pkg::OP_SW:
                begin
                    mem_ce_o   = 1'b1;
                    mem_we_o   = 1'b1;
                    mem_sel_o  = 4'b1111;
                    mem_data_o = reg2_i;
                end
                mem_pkg::OP_SC:
                begin
                    // the store only goes out while the link still holds
                    if (llbit_i)
                    begin
                        mem_ce_o   = 1'b1;
                        mem_we_o   = 1'b1;
                        mem_sel_o  = 4'b1111;
                        mem_data_o = reg2_i;
                        wb_sel_o   = mem_pkg::WB_SC_OK;
                        ll_we_o    = 1'b1;
                    end
                    else
                    begin
                        wb_sel_o = mem_pkg::WB_SC_FAIL;
                    end
                end
                default:
                begin
                end
            endcase
        end
    end

    assign mem_addr_o = mem_ce_o ? mem_addr_i : '0;

    // hold the pipe until the bus strobes back
    assign stall_o = mem_ce_o && (mem_we_o ? !mem_write_ready_i : !mem_data_valid_i);

endmodule

// ==== access/load_align.sv ====
// pulls the addressed byte or halfword out of the read word and extends it
`timescale 1ns/1ps

module load_align (
    input  mem_pkg::aluop_t aluop_i,
    input  logic [1:0]      addr_low_i,
    input  mem_pkg::word_t  mem_data_i,
    output mem_pkg::word_t  load_data_o
);

    mem_pkg::mem_word_u rd_word;
    logic [7:0]         rd_byte;
    logic [15:0]        rd_half;

    assign rd_word = mem_data_i;

    // lane 0 sits in the low bits
    assign rd_byte = rd_word.bytes[addr_low_i];
    assign rd_half = rd_word.halves[addr_low_i[1]];

    always_comb
    begin
        case (aluop_i)
            mem_pkg::OP_LB:
            begin
                load_data_o = {{24{rd_byte[7]}}, rd_byte};
            end
            mem_pkg::OP_LBU:
            begin
                load_data_o = {24'd0, rd_byte};
            end
            mem_pkg::OP_LH:
            begin
                load_data_o = {{16{rd_half[15]}}, rd_half};
            end
            mem_pkg::OP_LHU:
            begin
                load_data_o = {16'd0, rd_half};
            end
            mem_pkg::OP_LW, mem_pkg::OP_LL:
            begin
                load_data_o = mem_data_i;
            end
            default:
            begin
                load_data_o = '0;
            end
        endcase
    end

endmodule

// ==== logic/mem_wb_reg.sv ====
// memory-to-writeback pipeline register, also keeps the load-link bit
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             stall_i,
    input  logic [4:0]       wd_i,
    input  logic             wreg_i,
    input  mem_pkg::word_t   wdata_i,
    input  mem_pkg::word_t   load_data_i,
    input  mem_pkg::wb_sel_t wb_sel_i,
    input  logic             ll_we_i,
    input  logic             ll_value_i,
    output logic [4:0]       wb_wd_o,
    output logic             wb_wreg_o,
    output mem_pkg::word_t   wb_wdata_o,
    output logic             llbit_o
);

    mem_pkg::word_t wb_data;

    // SC reports its outcome as 1 or 0
    always_comb
    begin
        case (wb_sel_i)
            mem_pkg::WB_LOAD:    wb_data = load_data_i;
            mem_pkg::WB_SC_OK:   wb_data = 32'd1;
            mem_pkg::WB_SC_FAIL: wb_data = 32'd0;
            default:             wb_data = wdata_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wb_wd_o    <= '0;
            wb_wreg_o  <= 1'b0;
            wb_wdata_o <= '0;
        end
        else if (stall_i)
        begin
            // bubble while the bus access is outstanding
            wb_wd_o    <= '0;
            wb_wreg_o  <= 1'b0;
            wb_wdata_o <= '0;
        end
        else
        begin
            wb_wd_o    <= wd_i;
            wb_wreg_o  <= wreg_i;
            wb_wdata_o <= wb_data;
        end
    end

    // set by LL, cleared by a successful SC
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            llbit_o <= 1'b0;
        else if (!stall_i && ll_we_i)
            llbit_o <= ll_value_i;
    end

endmodule

// ==== logic/mem_stage.sv ====
// memory-access stage top, ties exception, bus control, load alignment and output register
`timescale 1ns/1ps

module mem_stage (
    input  logic            clk,
    input  logic            rst_n_i,
    // from execute
    input  mem_pkg::aluop_t aluop_i,
    input  mem_pkg::word_t  mem_addr_i,
    input  mem_pkg::word_t  reg2_i,
    input  logic [4:0]      wd_i,
    input  logic            wreg_i,
    input  mem_pkg::word_t  wdata_i,
    input  mem_pkg::word_t  excepttype_i,
    input  mem_pkg::word_t  inst_addr_i,
    // data bus
    output logic            mem_ce_o,
    output logic            mem_we_o,
    output mem_pkg::word_t  mem_addr_o,
    output logic [3:0]      mem_sel_o,
    output mem_pkg::word_t  mem_data_o,
    input  mem_pkg::word_t  mem_data_i,
    input  logic            mem_data_valid_i,
    input  logic            mem_write_ready_i,
    // CP0 and its writeback-stage write
    input  mem_pkg::word_t  cp0_status_i,
    input  mem_pkg::word_t  cp0_cause_i,
    input  mem_pkg::word_t  cp0_epc_i,
    input  logic            wb_cp0_we_i,
    input  logic [4:0]      wb_cp0_addr_i,
    input  mem_pkg::word_t  wb_cp0_data_i,
    output mem_pkg::word_t  excepttype_o,
    output mem_pkg::word_t  cp0_epc_o,
    output mem_pkg::word_t  badvaddr_o,
    // to writeback
    output logic [4:0]      wb_wd_o,
    output logic            wb_wreg_o,
    output mem_pkg::word_t  wb_wdata_o,
    output logic            stall_o
);

    mem_pkg::word_t   status_cur;
    mem_pkg::word_t   cause_cur;
    logic             except_hit;
    logic             llbit;
    logic             ll_we;
    logic             ll_value;
    mem_pkg::wb_sel_t wb_sel;
    mem_pkg::word_t   load_data;

    cp0_forward u_cp0_forward (
        .cp0_status_i  (cp0_status_i),
        .cp0_cause_i   (cp0_cause_i),
        .cp0_epc_i     (cp0_epc_i),
        .wb_cp0_we_i   (wb_cp0_we_i),
        .wb_cp0_addr_i (wb_cp0_addr_i),
        .wb_cp0_data_i (wb_cp0_data_i),
        .status_o      (status_cur),
        .cause_o       (cause_cur),
        .epc_o         (cp0_epc_o)
    );

    except_arbiter u_except_arbiter (
        .rst_n_i      (rst_n_i),
        .excepttype_i (excepttype_i),
        .inst_addr_i  (inst_addr_i),
        .mem_addr_i   (mem_addr_i),
        .status_i     (status_cur),
        .cause_i      (cause_cur),
        .excepttype_o (excepttype_o),
        .except_o     (except_hit),
        .badvaddr_o   (badvaddr_o)
    );

    mem_access_ctrl u_mem_access_ctrl (
        .aluop_i           (aluop_i),
        .mem_addr_i        (mem_addr_i),
        .reg2_i            (reg2_i),
        .except_i          (except_hit),
        .llbit_i           (llbit),
        .mem_data_valid_i  (mem_data_valid_i),
        .mem_write_ready_i (mem_write_ready_i),
        .mem_ce_o          (mem_ce_o),
        .mem_we_o          (mem_we_o),
        .mem_addr_o        (mem_addr_o),
        .mem_sel_o         (mem_sel_o),
        .mem_data_o        (mem_data_o),
        .wb_sel_o          (wb_sel),
        .ll_we_o           (ll_we),
        .ll_value_o        (ll_value),
        .stall_o           (stall_o)
    );

    load_align u_load_align (
        .aluop_i     (aluop_i),
        .addr_low_i  (mem_addr_i[1:0]),
        .mem_data_i  (mem_data_i),
        .load_data_o (load_data)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_o),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .wdata_i     (wdata_i),
        .load_data_i (load_data),
        .wb_sel_i    (wb_sel),
        .ll_we_i     (ll_we),
        .ll_value_i  (ll_value),
        .wb_wd_o     (wb_wd_o),
        .wb_wreg_o   (wb_wreg_o),
        .wb_wdata_o  (wb_wdata_o),
        .llbit_o     (llbit)
    );

endmodule

// ==== testbench/mem_stage_properties.sv ====
// concurrent checks on bus control and reset behaviour, bound into every mem_stage
`timescale 1ns/1ps

module mem_stage_properties (
    input logic clk,
    input logic rst_n_i,
    input logic mem_ce_i,
    input logic mem_we_i,
    input logic except_i,
    input logic wb_wreg_i
);

    // write strobe only with chip enable
    a_we_has_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_we_i |-> mem_ce_i)
        else $error("mem_we_o high without mem_ce_o");

    // an excepted instruction never reaches the bus
    a_except_no_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
        except_i |-> !mem_ce_i)
        else $error("mem_ce_o high while an exception is taken");

    // first cycle out of reset carries no writeback
    a_reset_bubble: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !wb_wreg_i)
        else $error("wb_wreg_o high in the first cycle after reset");

endmodule

bind mem_stage mem_stage_properties u_properties (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .mem_ce_i  (mem_ce_o),
    .mem_we_i  (mem_we_o),
    .except_i  (except_hit),
    .wb_wreg_i (wb_wreg_o)
);

// ==== testbench/tb_mem_stage.sv ====
// testbench for mem_stage, applies a vector table against a bus model with random latency
`timescale 1ns/1ps

module tb_mem_stage;

    typedef struct packed {
        mem_pkg::aluop_t op;
        mem_pkg::word_t  addr;
        mem_pkg::word_t  reg2;
        mem_pkg::word_t  alu;
        mem_pkg::word_t  exc;
        mem_pkg::word_t  pc;
        mem_pkg::word_t  status;
        mem_pkg::word_t  cause;
        mem_pkg::word_t  rdata;
        logic            wreg;
        logic [4:0]      wd;
        logic            cp_we;
        logic [4:0]      cp_addr;
        mem_pkg::word_t  cp_data;
        // expected responses
        logic [3:0]      e_sel;
        logic            e_we;
        mem_pkg::word_t  e_data;
        mem_pkg::word_t  e_exc;
        mem_pkg::word_t  e_bad;
        mem_pkg::word_t  e_epc;
        mem_pkg::word_t  e_wb;
        logic            e_wreg;
    } entry_t;

    localparam mem_pkg::word_t BASE   = 32'h0000_0200;
    localparam mem_pkg::word_t PC     = 32'h0000_1000;
    localparam mem_pkg::word_t REG2   = 32'h1357_9BDF;
    localparam mem_pkg::word_t ALU    = 32'h5A5A_1234;
    localparam mem_pkg::word_t RDATA  = 32'h9AB4_E2F6;
    localparam mem_pkg::word_t EPC_IN = 32'h8000_0180;

    // single-bit excepttype_i patterns
    localparam mem_pkg::word_t X_SYS  = 32'd1 << mem_pkg::SYSCALL_IDX;
    localparam mem_pkg::word_t X_BRK  = 32'd1 << mem_pkg::BREAK_IDX;
    localparam mem_pkg::word_t X_RI   = 32'd1 << mem_pkg::INSTINVALID_IDX;
    localparam mem_pkg::word_t X_TRAP = 32'd1 << mem_pkg::TRAP_IDX;
    localparam mem_pkg::word_t X_OV   = 32'd1 << mem_pkg::OVERFLOW_IDX;
    localparam mem_pkg::word_t X_ADEL = 32'd1 << mem_pkg::ADEL_IDX;
    localparam mem_pkg::word_t X_ADES = 32'd1 << mem_pkg::ADES_IDX;
    localparam mem_pkg::word_t X_ERET = 32'd1 << mem_pkg::ERET_IDX;

    logic            clk;
    logic            rst_n_i;
    mem_pkg::aluop_t aluop_i;
    mem_pkg::word_t  mem_addr_i;
    mem_pkg::word_t  reg2_i;
    logic [4:0]      wd_i;
    logic            wreg_i;
    mem_pkg::word_t  wdata_i;
    mem_pkg::word_t  excepttype_i;
    mem_pkg::word_t  inst_addr_i;
    logic            mem_ce_o;
    logic            mem_we_o;
    mem_pkg::word_t  mem_addr_o;
    logic [3:0]      mem_sel_o;
    mem_pkg::word_t  mem_data_o;
    mem_pkg::word_t  mem_data_i;
    logic            mem_data_valid_i;
    logic            mem_write_ready_i;
    mem_pkg::word_t  cp0_status_i;
    mem_pkg::word_t  cp0_cause_i;
    mem_pkg::word_t  cp0_epc_i;
    logic            wb_cp0_we_i;
    logic [4:0]      wb_cp0_addr_i;
    mem_pkg::word_t  wb_cp0_data_i;
    mem_pkg::word_t  excepttype_o;
    mem_pkg::word_t  cp0_epc_o;
    mem_pkg::word_t  badvaddr_o;
    logic [4:0]      wb_wd_o;
    logic            wb_wreg_o;
    mem_pkg::word_t  wb_wdata_o;
    logic            stall_o;

    entry_t tbl[$];
    int     errors = 0;
    int     cycles = 0;
    int     cycle_limit;
    int     seed = 32'h490e7bfc;

    mem_stage dut (.*);

    always #4 clk = ~clk;

    // abort if the table stops making progress
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout after %0d cycles, the vector table did not complete", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic report_mismatch(string name, mem_pkg::word_t exp, mem_pkg::word_t act);
        errors = errors + 1;
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
    endtask

    function automatic entry_t blank_entry(mem_pkg::aluop_t op, mem_pkg::word_t addr);
        entry_t e;
        e       = '0;
        e.op    = op;
        e.addr  = addr;
        e.reg2  = REG2;
        e.alu   = ALU;
        e.pc    = PC;
        // nonzero destination that changes from entry to entry
        e.wd    = 5'(tbl.size() % 31 + 1);
        e.e_bad = addr;
        e.e_epc = EPC_IN;
        e.e_wb  = ALU;
        return e;
    endfunction

    task automatic add_load(mem_pkg::aluop_t op, mem_pkg::word_t off, logic [3:0] sel,
                            mem_pkg::word_t wb);
        entry_t e;
        e        = blank_entry(op, BASE + off);
        e.rdata  = RDATA;
        e.wreg   = 1'b1;
        e.e_wreg = 1'b1;
        e.e_sel  = sel;
        e.e_wb   = wb;
        tbl.push_back(e);
    endtask

    task automatic add_store(mem_pkg::aluop_t op, mem_pkg::word_t off, logic [3:0] sel,
                             mem_pkg::word_t data);
        entry_t e;
        e        = blank_entry(op, BASE + off);
        e.e_sel  = sel;
        e.e_we   = 1'b1;
        e.e_data = data;
        tbl.push_back(e);
    endtask

    task automatic add_sc(logic ok);
        entry_t e;
        e        = blank_entry(mem_pkg::OP_SC, BASE + 32'h10);
        e.wreg   = 1'b1;
        e.e_wreg = 1'b1;
        e.e_wb   = 32'd0;
        if (ok)
        begin
            e.e_sel  = 4'b1111;
            e.e_we   = 1'b1;
            e.e_data = REG2;
            e.e_wb   = 32'd1;
        end
        tbl.push_back(e);
    endtask

    task automatic add_exc(mem_pkg::aluop_t op, mem_pkg::word_t pc, mem_pkg::word_t exc,
                           mem_pkg::word_t code, mem_pkg::word_t bad);
        entry_t e;
        e        = blank_entry(op, BASE + 32'd4);
        e.pc     = pc;
        e.exc    = exc;
        e.wreg   = 1'b1;
        e.e_wreg = 1'b1;
        e.e_exc  = code;
        e.e_bad  = bad;
        tbl.push_back(e);
    endtask

    task automatic add_cp0(logic we, logic [4:0] addr, mem_pkg::word_t data,
                           mem_pkg::word_t status, mem_pkg::word_t cause,
                           mem_pkg::word_t code, mem_pkg::word_t epc);
        entry_t e;
        e         = blank_entry(mem_pkg::OP_NONE, BASE + 32'd8);
        e.cp_we   = we;
        e.cp_addr = addr;
        e.cp_data = data;
        e.status  = status;
        e.cause   = cause;
        e.e_exc   = code;
        e.e_epc   = epc;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // no link yet, so the SC must fail
        add_sc(1'b0);
        add_load(mem_pkg::OP_LB, 32'd0, 4'b0001, 32'hFFFF_FFF6);
        add_load(mem_pkg::OP_LB, 32'd1, 4'b0010, 32'hFFFF_FFE2);
        add_load(mem_pkg::OP_LB, 32'd2, 4'b0100, 32'hFFFF_FFB4);
        add_load(mem_pkg::OP_LB, 32'd3, 4'b1000, 32'hFFFF_FF9A);
        add_load(mem_pkg::OP_LBU, 32'd0, 4'b0001, 32'h0000_00F6);
        add_load(mem_pkg::OP_LBU, 32'd1, 4'b0010, 32'h0000_00E2);
        add_load(mem_pkg::OP_LBU, 32'd2, 4'b0100, 32'h0000_00B4);
        add_load(mem_pkg::OP_LBU, 32'd3, 4'b1000, 32'h0000_009A);
        add_load(mem_pkg::OP_LH, 32'd0, 4'b0011, 32'hFFFF_E2F6);
        add_load(mem_pkg::OP_LH, 32'd2, 4'b1100, 32'hFFFF_9AB4);
        add_load(mem_pkg::OP_LHU, 32'd0, 4'b0011, 32'h0000_E2F6);
        add_load(mem_pkg::OP_LHU, 32'd2, 4'b1100, 32'h0000_9AB4);
        add_load(mem_pkg::OP_LW, 32'd0, 4'b1111, RDATA);
        add_load(mem_pkg::OP_LL, 32'd0, 4'b1111, RDATA);
        add_store(mem_pkg::OP_SB, 32'd0, 4'b0001, 32'hDFDF_DFDF);
        add_store(mem_pkg::OP_SB, 32'd1, 4'b0010, 32'hDFDF_DFDF);
        add_store(mem_pkg::OP_SB, 32'd2, 4'b0100, 32'hDFDF_DFDF);
        add_store(mem_pkg::OP_SB, 32'd3, 4'b1000, 32'hDFDF_DFDF);
        add_store(mem_pkg::OP_SH, 32'd0, 4'b0011, 32'h9BDF_9BDF);
        add_store(mem_pkg::OP_SH, 32'd2, 4'b1100, 32'h9BDF_9BDF);
        add_store(mem_pkg::OP_SW, 32'd0, 4'b1111, REG2);
        // link from the LL above still holds once, then it is gone
        add_sc(1'b1);
        add_sc(1'b0);
        add_exc(mem_pkg::OP_NONE, PC, X_OV | X_TRAP | X_BRK, mem_pkg::EXC_BREAK, BASE + 4);
        add_exc(mem_pkg::OP_NONE, PC, X_ERET | X_ADES | X_OV, mem_pkg::EXC_OV, BASE + 4);
        add_exc(mem_pkg::OP_NONE, PC, X_RI | X_SYS | X_ADEL, mem_pkg::EXC_SYSCALL, BASE + 4);
        add_exc(mem_pkg::OP_NONE, PC, X_ERET | X_ADES | X_TRAP, mem_pkg::EXC_TRAP, BASE + 4);
        add_exc(mem_pkg::OP_NONE, PC, X_ERET | X_ADES | X_ADEL, mem_pkg::EXC_ADEL, BASE + 4);
        add_exc(mem_pkg::OP_NONE, PC, X_ERET | X_ADES, mem_pkg::EXC_ADES, BASE + 4);
        add_exc(mem_pkg::OP_NONE, PC, X_ERET, mem_pkg::EXC_ERET, BASE + 4);
        add_exc(mem_pkg::OP_SW, PC, X_ADES, mem_pkg::EXC_ADES, BASE + 4);
        add_exc(mem_pkg::OP_NONE, 32'h0, X_SYS | X_BRK, 32'h0, BASE + 4);
        add_exc(mem_pkg::OP_NONE, 32'h0000_1002, X_ADEL, mem_pkg::EXC_ADEL, 32'h0000_1002);
        // pending IP2 stays quiet until the forwarded Status enables it
        add_cp0(1'b0, 5'd0, 32'h0, 32'h0, 32'h400, 32'h0, EPC_IN);
        add_cp0(1'b1, mem_pkg::CP0_STATUS, 32'h401, 32'h0, 32'h400, mem_pkg::EXC_INT, EPC_IN);
        add_cp0(1'b1, mem_pkg::CP0_EPC, 32'hBFC0_0380, 32'h0, 32'h0, 32'h0, 32'hBFC0_0380);
        // cause write clears software IP, hardware IP7 must survive
        add_cp0(1'b1, mem_pkg::CP0_CAUSE, 32'h0, 32'h101, 32'h8300, 32'h0, EPC_IN);
        add_cp0(1'b1, mem_pkg::CP0_CAUSE, 32'h0, 32'h8001, 32'h8300, mem_pkg::EXC_INT, EPC_IN);
    endtask

    task automatic check_bus(entry_t e, logic exp_stall);
        logic access;
        access = (e.e_sel != 4'b0000);
        if (mem_ce_o !== access)
            report_mismatch("mem_ce_o", {31'd0, access}, {31'd0, mem_ce_o});
        if (mem_we_o !== e.e_we)
            report_mismatch("mem_we_o", {31'd0, e.e_we}, {31'd0, mem_we_o});
        if (mem_sel_o !== e.e_sel)
            report_mismatch("mem_sel_o", {28'd0, e.e_sel}, {28'd0, mem_sel_o});
        if (e.e_we && (mem_data_o !== e.e_data))
            report_mismatch("mem_data_o", e.e_data, mem_data_o);
        if (access && (mem_addr_o !== e.addr))
            report_mismatch("mem_addr_o", e.addr, mem_addr_o);
        if (excepttype_o !== e.e_exc)
            report_mismatch("excepttype_o", e.e_exc, excepttype_o);
        if (badvaddr_o !== e.e_bad)
            report_mismatch("badvaddr_o", e.e_bad, badvaddr_o);
        if (cp0_epc_o !== e.e_epc)
            report_mismatch("cp0_epc_o", e.e_epc, cp0_epc_o);
        if (stall_o !== exp_stall)
            report_mismatch("stall_o", {31'd0, exp_stall}, {31'd0, stall_o});
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the completing edge
    task automatic run_entry(entry_t e);
        int   lat;
        int   k;
        logic access;
        access = (e.e_sel != 4'b0000);
        lat    = 0;
        if (access)
            lat = $unsigned($random(seed)) % 4;
        aluop_i       = e.op;
        mem_addr_i    = e.addr;
        reg2_i        = e.reg2;
        wdata_i       = e.alu;
        wreg_i        = e.wreg;
        wd_i          = e.wd;
        excepttype_i  = e.exc;
        inst_addr_i   = e.pc;
        cp0_status_i  = e.status;
        cp0_cause_i   = e.cause;
        wb_cp0_we_i   = e.cp_we;
        wb_cp0_addr_i = e.cp_addr;
        wb_cp0_data_i = e.cp_data;
        for (k = 0; k <= lat; k++)
        begin
            if (k > 0)
            begin
                @(posedge clk);
                #1;
                // previous edge was stalled
                if (wb_wreg_o !== 1'b0)
                    report_mismatch("wb_wreg_o", 32'd0, {31'd0, wb_wreg_o});
            end
            mem_data_valid_i  = access && !e.e_we && (k == lat);
            mem_write_ready_i = access && e.e_we && (k == lat);
            mem_data_i        = mem_data_valid_i ? e.rdata : 32'h0;
            @(negedge clk);
            check_bus(e, access && (k < lat));
        end
        @(posedge clk);
        #1;
        mem_data_valid_i  = 1'b0;
        mem_write_ready_i = 1'b0;
        mem_data_i        = 32'h0;
        if (wb_wreg_o !== e.e_wreg)
            report_mismatch("wb_wreg_o", {31'd0, e.e_wreg}, {31'd0, wb_wreg_o});
        if (wb_wd_o !== e.wd)
            report_mismatch("wb_wd_o", {27'd0, e.wd}, {27'd0, wb_wd_o});
        if (wb_wdata_o !== e.e_wb)
            report_mismatch("wb_wdata_o", e.e_wb, wb_wdata_o);
    endtask

    initial
    begin
        int i;
        clk               = 1'b0;
        rst_n_i           = 1'b0;
        aluop_i           = mem_pkg::OP_NONE;
        mem_addr_i        = 32'h0;
        reg2_i            = 32'h0;
        wd_i              = 5'd9;
        wreg_i            = 1'b0;
        wdata_i           = 32'h0;
        mem_data_i        = 32'h0;
        mem_data_valid_i  = 1'b0;
        mem_write_ready_i = 1'b0;
        cp0_status_i      = 32'h0;
        cp0_cause_i       = 32'h0;
        cp0_epc_i         = EPC_IN;
        wb_cp0_we_i       = 1'b0;
        wb_cp0_addr_i     = 5'd0;
        wb_cp0_data_i     = 32'h0;
        // live pc with a syscall, still no code while in reset
        inst_addr_i       = PC;
        excepttype_i      = X_SYS;
        build_table();
        cycle_limit = tbl.size() * 6 + 20;
        #2;
        if (excepttype_o !== 32'h0)
            report_mismatch("excepttype_o", 32'h0, excepttype_o);
        repeat (2) @(posedge clk);
        #1;
        rst_n_i      = 1'b1;
        inst_addr_i  = 32'h0;
        excepttype_i = 32'h0;
        if (wb_wreg_o !== 1'b0)
            report_mismatch("wb_wreg_o", 32'h0, {31'd0, wb_wreg_o});
        for (i = 0; i < tbl.size(); i++)
            run_entry(tbl[i]);
        $display("%0d entries applied, %0d errors", tbl.size(), errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== sources.f ====
common/mem_pkg.sv
exception/cp0_forward.sv
exception/except_arbiter.sv
access/mem_access_ctrl.sv
access/load_align.sv
logic/mem_wb_reg.sv
logic/mem_stage.sv
testbench/mem_stage_properties.sv
testbench/tb_mem_stage.sv

// ==== Makefile ====
SRCS := $(shell cat sources.f)

.PHONY: run clean

run: obj_dir/Vtb_mem_stage
	./obj_dir/Vtb_mem_stage > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "Something failed" sim.log; then exit 1; fi

obj_dir/Vtb_mem_stage: sources.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_mem_stage -f sources.f

clean:
	rm -rf obj_dir sim.log
